// ==== cache_test_top.f ====
cache_test_pkg.sv
pacer_cfg.sv
req_pacer.sv
test_sequencer.sv
dm_cache.sv
main_mem.sv
cache_test_top.sv
tb_clock.sv
tb_cache_test.sv

// ==== Makefile ====
SRCS = $(wildcard *.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_cache_test: cache_test_top.f $(SRCS)
	verilator --binary --timing --assert -f cache_test_top.f \
		--top-module tb_cache_test -o Vtb_cache_test

run: obj_dir/Vtb_cache_test
	./obj_dir/Vtb_cache_test | tee sim.log
	@if grep -q "Test failures found" sim.log; then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@grep -q "All tests passed!" sim.log || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf obj_dir sim.log

// ==== tb_cache_test.sv ====
// Testbench for the cache exerciser. Runs a table of pacing settings, each from
// reset to done, and checks the result counters against a direct-mapped model.
`timescale 1ns/1ps
`default_nettype none

module tb_cache_test;

  // 24 words leave lines 8..15 holding the low words, so the reads mix hits and misses
  localparam int NUM_WORDS   = 24;
  localparam int MEM_LATENCY = 4;
  localparam int NUM_ROWS    = 4;
  localparam int IDLE_CYCLES = 100;

  typedef struct {
    bit keep_reset;
    int holdoff;
    int distance;
    int exp_req;
    int exp_hits;
    int exp_errs;
  } row_t;

  logic       clk;
  logic       rst;
  logic       cfg_we;
  logic [1:0] cfg_sel;
  logic [7:0] cfg_wdata;
  logic       done;
  logic [7:0] req_count;
  logic [7:0] hit_count;
  logic [7:0] err_count;

  row_t rows [NUM_ROWS];
  int   timeout_limit = 0;
  int   cycle_count = 0;

  tb_clock #(.PERIOD(20ns)) tb_clock_i (.clk(clk));

  cache_test_top #(
    .NUM_WORDS   (NUM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) cache_test_top_i (
    .clk       (clk),
    .rst       (rst),
    .cfg_we    (cfg_we),
    .cfg_sel   (cfg_sel),
    .cfg_wdata (cfg_wdata),
    .done      (done),
    .req_count (req_count),
    .hit_count (hit_count),
    .err_count (err_count)
  );

  // Direct-mapped model with the low 4 address bits as index and the high 4 as tag
  // Writes allocate and read misses refill the line
  function automatic int model_hits(input int num_words);
    bit [15:0] line_valid;
    int        line_tag [16];
    int        hits;
    hits = 0;
    line_valid = '0;
    for (int a = 0; a < num_words; a++) begin
      line_valid[a % 16] = 1'b1;
      line_tag[a % 16] = a / 16;
    end
    for (int a = 0; a < num_words; a++) begin
      if (line_valid[a % 16] && line_tag[a % 16] == a / 16) begin
        hits++;
      end else begin
        line_valid[a % 16] = 1'b1;
        line_tag[a % 16] = a / 16;
      end
    end
    return hits;
  endfunction

  task automatic load_table();
    int hits;
    hits = model_hits(NUM_WORDS);
    rows[0] = '{1'b1, 80, 0, 2 * NUM_WORDS, hits, 0};
    rows[1] = '{1'b0, 0, 1, 2 * NUM_WORDS, hits, 0};
    rows[2] = '{1'b0, 0, 6, 2 * NUM_WORDS, hits, 0};
    rows[3] = '{1'b0, 12, 3, 2 * NUM_WORDS, hits, 0};
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("Test failures found");
      $fatal(1, "counter check failed");
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic write_cfg(input logic [1:0] sel, input logic [7:0] data);
    @(posedge clk);
    cfg_we    <= 1'b1;
    cfg_sel   <= sel;
    cfg_wdata <= data;
    @(posedge clk);
    cfg_we    <= 1'b0;
  endtask

  // Watchdog over the whole run
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit > 0 && cycle_count > timeout_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("Test failures found");
      $fatal(1, "simulation timeout");
    end
  end

  initial begin
    rst       = 1'b1;
    cfg_we    = 1'b0;
    cfg_sel   = 2'd0;
    cfg_wdata = 8'd0;
    load_table();
    for (int r = 0; r < NUM_ROWS; r++) begin
      timeout_limit += rows[r].holdoff +
        2 * NUM_WORDS * (3 * (rows[r].distance + 1) + MEM_LATENCY + 2) + IDLE_CYCLES + 20;
    end
    timeout_limit += 100;

    for (int r = 0; r < NUM_ROWS; r++) begin
      $display("Row %0d: holdoff %0d, distance %0d", r, rows[r].holdoff, rows[r].distance);
      apply_reset();
      if (!rows[r].keep_reset) begin
        write_cfg(2'd0, 8'(rows[r].holdoff));
        write_cfg(2'd1, 8'(rows[r].distance));
      end
      // Nothing may move before go
      repeat (IDLE_CYCLES) begin
        @(negedge clk);
        check_value("done", done, 0);
        check_value("req_count", req_count, 0);
      end
      write_cfg(2'd2, 8'd1);
      do @(negedge clk); while (!done);
      check_value("req_count", req_count, rows[r].exp_req);
      check_value("hit_count", hit_count, rows[r].exp_hits);
      check_value("err_count", err_count, rows[r].exp_errs);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
// Free-running clock source for the cache exerciser testbench.
// The period is a parameter, 20 ns by default.
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter realtime PERIOD = 20ns
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== cache_test_top.sv ====
// Top level of the cache exerciser. Wires configuration, pacer, sequencer, cache
// and memory together; results come out as counters and a done level.
`timescale 1ns/1ps
`default_nettype none

module cache_test_top
  import cache_test_pkg::*;
#(
  parameter int NUM_WORDS   = 32,
  parameter int MEM_LATENCY = 4
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       cfg_we,
  input  logic [1:0] cfg_sel,
  input  logic [7:0] cfg_wdata,
  output logic       done,
  output logic [7:0] req_count,
  output logic [7:0] hit_count,
  output logic [7:0] err_count
);

  logic [7:0]  holdoff_cfg;
  logic [3:0]  distance_cfg;
  logic        start;
  logic        valid;
  logic        ready;
  logic        stop;
  cache_req_t  req;
  cache_resp_t resp;
  mem_req_t    mem_req;
  data_t       mem_rdata;
  logic        mem_rvalid;

  pacer_cfg pacer_cfg_i (
    .clk          (clk),
    .rst          (rst),
    .cfg_we       (cfg_we),
    .cfg_sel      (cfg_sel),
    .cfg_wdata    (cfg_wdata),
    .holdoff_cfg  (holdoff_cfg),
    .distance_cfg (distance_cfg),
    .start        (start)
  );

  req_pacer req_pacer_i (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .holdoff_cfg  (holdoff_cfg),
    .distance_cfg (distance_cfg),
    .ready        (ready),
    .stop         (stop),
    .valid        (valid)
  );

  test_sequencer #(.NUM_WORDS(NUM_WORDS)) test_sequencer_i (
    .clk       (clk),
    .rst       (rst),
    .valid     (valid),
    .ready     (ready),
    .resp      (resp),
    .req       (req),
    .stop      (stop),
    .done      (done),
    .req_count (req_count),
    .hit_count (hit_count),
    .err_count (err_count)
  );

  dm_cache #(.MEM_LATENCY(MEM_LATENCY)) dm_cache_i (
    .clk        (clk),
    .rst        (rst),
    .valid      (valid),
    .req        (req),
    .mem_rdata  (mem_rdata),
    .mem_rvalid (mem_rvalid),
    .ready      (ready),
    .resp       (resp),
    .mem_req    (mem_req)
  );

  main_mem #(.MEM_LATENCY(MEM_LATENCY)) main_mem_i (
    .clk        (clk),
    .mem_req    (mem_req),
    .mem_rdata  (mem_rdata),
    .mem_rvalid (mem_rvalid)
  );

endmodule

`default_nettype wire

// ==== main_mem.sv ====
// Backing word memory for the cache. Writes land at once, and reads come back
// through a delay line exactly MEM_LATENCY cycles after the read strobe.
`timescale 1ns/1ps
`default_nettype none

module main_mem
  import cache_test_pkg::*;
#(
  parameter int MEM_LATENCY = 4
) (
  input  logic     clk,
  input  mem_req_t mem_req,
  output data_t    mem_rdata,
  output logic     mem_rvalid
);

  localparam int DEPTH = 2 ** ADDR_W;

  data_t                  mem [DEPTH];
  data_t                  rdata_pipe [MEM_LATENCY];
  logic [MEM_LATENCY-1:0] rvalid_pipe;

  always_ff @(posedge clk) begin
    if (mem_req.wr) begin
      mem[mem_req.addr.word] <= mem_req.data;
    end
  end

  // Stage 0 takes the array read, later stages only delay it
  always_ff @(posedge clk) begin
    rdata_pipe[0]  <= mem[mem_req.addr.word];
    rvalid_pipe[0] <= mem_req.rd;
    for (int i = 1; i < MEM_LATENCY; i++) begin
      rdata_pipe[i]  <= rdata_pipe[i-1];
      rvalid_pipe[i] <= rvalid_pipe[i-1];
    end
  end

  assign mem_rdata  = rdata_pipe[MEM_LATENCY-1];
  assign mem_rvalid = rvalid_pipe[MEM_LATENCY-1];

endmodule

`default_nettype wire

// ==== dm_cache.sv ====
// Direct-mapped, write-through, write-allocate cache with one-word lines.
// Read misses stall the requester by dropping ready until the memory refills the line.
`timescale 1ns/1ps
`default_nettype none

module dm_cache
  import cache_test_pkg::*;
#(
  parameter int MEM_LATENCY = 4
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        valid,
  input  cache_req_t  req,
  input  data_t       mem_rdata,
  input  logic        mem_rvalid,
  output logic        ready,
  output cache_resp_t resp,
  output mem_req_t    mem_req
);

  localparam int LINES = 2 ** INDEX_W;

  logic [LINES-1:0]   line_valid;
  logic [TAG_W-1:0]   tag_store  [LINES];
  data_t              data_store [LINES];
  logic               pending;
  addr_t              miss_addr;
  logic [INDEX_W-1:0] idx;
  logic               hit;
  logic               accept;
  logic               miss_accept;
  logic               refill;

  assign idx         = req.addr.fields.index;
  assign hit         = line_valid[idx] && (tag_store[idx] == req.addr.fields.tag);
  assign ready       = !pending;
  assign accept      = valid && ready;
  assign miss_accept = accept && !req.write && !hit;
  assign refill      = pending && mem_rvalid;

  always_ff @(posedge clk) begin
    if (rst) begin
      pending    <= 1'b0;
      line_valid <= '0;
      resp       <= '0;
      mem_req    <= '0;
    end else begin
      resp.valid <= 1'b0;
      mem_req.rd <= 1'b0;
      mem_req.wr <= 1'b0;
      if (accept && req.write) begin
        // Write through and allocate in the same cycle
        line_valid[idx] <= 1'b1;
        mem_req <= '{rd: 1'b0, wr: 1'b1, addr: req.addr, data: req.data};
      end else if (accept && hit) begin
        resp <= '{valid: 1'b1, data: data_store[idx], hit: 1'b1};
      end else if (miss_accept) begin
        pending <= 1'b1;
        mem_req <= '{rd: 1'b1, wr: 1'b0, addr: req.addr, data: '0};
      end else if (refill) begin
        pending <= 1'b0;
        line_valid[miss_addr.fields.index] <= 1'b1;
        resp <= '{valid: 1'b1, data: mem_rdata, hit: 1'b0};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && req.write) begin
      tag_store[idx]  <= req.addr.fields.tag;
      data_store[idx] <= req.data;
    end
    if (miss_accept) begin
      miss_addr <= req.addr;
    end
    if (refill) begin
      tag_store[miss_addr.fields.index]  <= miss_addr.fields.tag;
      data_store[miss_addr.fields.index] <= mem_rdata;
    end
  end

  // The refill lands exactly when the memory answers, and ready is still low then
  a_miss_window: assert property (@(posedge clk) disable iff (rst)
    miss_accept |-> ##(MEM_LATENCY + 1) (mem_rvalid && !ready));

endmodule

`default_nettype wire

// ==== test_sequencer.sv ====
// Test sequencer. Writes the pattern to every test word, then reads them all back
// in order, checks each read response and counts requests, hits and mismatches.
`timescale 1ns/1ps
`default_nettype none

module test_sequencer
  import cache_test_pkg::*;
#(
  parameter int NUM_WORDS = 32
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        valid,
  input  logic        ready,
  input  cache_resp_t resp,
  output cache_req_t  req,
  output logic        stop,
  output logic        done,
  output logic [7:0]  req_count,
  output logic [7:0]  hit_count,
  output logic [7:0]  err_count
);

  localparam logic [7:0] WORDS = 8'(NUM_WORDS);
  localparam logic [7:0] TOTAL = 8'(2 * NUM_WORDS);

  logic       accept;
  logic       is_write;
  logic [7:0] word_addr;
  addr_t      req_addr;
  logic [7:0] rd_count;
  data_t      expected;

  assign accept    = valid && ready;
  assign is_write  = (req_count < WORDS);
  assign word_addr = is_write ? req_count : req_count - WORDS;

  // Request follows the count, so it holds still until accepted
  assign req_addr.word = word_addr;
  assign req = '{write: is_write, addr: req_addr, data: data_t'(word_addr) ^ DATA_KEY};

  assign stop     = (req_count == TOTAL);
  assign expected = data_t'(rd_count) ^ DATA_KEY;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_count <= 8'd0;
      rd_count  <= 8'd0;
      hit_count <= 8'd0;
      err_count <= 8'd0;
      done      <= 1'b0;
    end else begin
      if (accept) begin
        req_count <= req_count + 8'd1;
      end
      if (resp.valid) begin
        rd_count  <= rd_count + 8'd1;
        hit_count <= hit_count + 8'(resp.hit);
        err_count <= err_count + 8'(resp.data != expected);
        if (rd_count == WORDS - 8'd1) begin
          done <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== req_pacer.sv ====
// Request pacer. After start it waits out the holdoff, then raises valid once per
// three-phase cycle, with distance counting the ready cycles between phase steps.
`timescale 1ns/1ps
`default_nettype none

module req_pacer (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  logic [7:0] holdoff_cfg,
  input  logic [3:0] distance_cfg,
  input  logic       ready,
  input  logic       stop,
  output logic       valid
);

  localparam logic [1:0] PH_IDLE = 2'd0;
  localparam logic [1:0] PH_REQ  = 2'd1;
  localparam logic [1:0] PH_GAP1 = 2'd2;
  localparam logic [1:0] PH_GAP2 = 2'd3;

  logic       running;
  logic [7:0] holdoff;
  logic       holdoff_counting;
  logic [3:0] distance;
  logic       distance_restart;
  logic       step;
  logic [1:0] phase;
  logic [1:0] next_phase;

  assign holdoff_counting = (holdoff != 8'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      running <= 1'b0;
      holdoff <= 8'd0;
    end else if (start) begin
      running <= 1'b1;
      holdoff <= holdoff_cfg;
    end else begin
      if (stop) begin
        running <= 1'b0;
      end
      if (holdoff_counting) begin
        holdoff <= holdoff - 8'd1;
      end
    end
  end

  // Distance only moves with ready, so a stalled request keeps its slot
  assign distance_restart = (distance == distance_cfg);

  always_ff @(posedge clk) begin
    if (rst) begin
      distance <= 4'd0;
    end else if (!running || holdoff_counting) begin
      distance <= 4'd0;
    end else if (ready) begin
      distance <= distance_restart ? 4'd0 : distance + 4'd1;
    end
  end

  assign step = running && ready && distance_restart && !holdoff_counting;

  always_comb begin
    case (phase)
      PH_IDLE: next_phase = PH_REQ;
      PH_REQ:  next_phase = PH_GAP1;
      PH_GAP1: next_phase = PH_GAP2;
      PH_GAP2: next_phase = PH_REQ;
      default: next_phase = PH_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst || start) begin
      phase <= PH_IDLE;
    end else if (step) begin
      phase <= next_phase;
    end
  end

  assign valid = running && (phase == PH_REQ) && (distance == 4'd0);

  // A request that is not taken must still be offered on the next cycle
  a_valid_held: assert property (@(posedge clk) disable iff (rst)
    (valid && !ready) |=> valid);

endmodule

`default_nettype wire

// ==== pacer_cfg.sv ====
// Pacing configuration registers written over a small select/data port.
// A write to the go register produces a single-cycle start pulse.
`timescale 1ns/1ps
`default_nettype none

module pacer_cfg (
  input  logic       clk,
  input  logic       rst,
  input  logic       cfg_we,
  input  logic [1:0] cfg_sel,
  input  logic [7:0] cfg_wdata,
  output logic [7:0] holdoff_cfg,
  output logic [3:0] distance_cfg,
  output logic       start
);

  localparam logic [1:0] SEL_HOLDOFF  = 2'd0;
  localparam logic [1:0] SEL_DISTANCE = 2'd1;
  localparam logic [1:0] SEL_GO       = 2'd2;

  localparam logic [7:0] HOLDOFF_RESET = 8'd80;

  always_ff @(posedge clk) begin
    if (rst) begin
      holdoff_cfg  <= HOLDOFF_RESET;
      distance_cfg <= 4'd0;
      start        <= 1'b0;
    end else begin
      // Go carries no data, any write to it fires the pulse
      start <= cfg_we && (cfg_sel == SEL_GO);
      if (cfg_we && (cfg_sel == SEL_HOLDOFF)) begin
        holdoff_cfg <= cfg_wdata;
      end
      if (cfg_we && (cfg_sel == SEL_DISTANCE)) begin
        distance_cfg <= cfg_wdata[3:0];
      end
    end
  end

endmodule

`default_nettype wire

// ==== cache_test_pkg.sv ====
// Shared widths, the address view and the request and response structs of the
// cache exerciser. Modules import what they need from here.
`default_nettype none

package cache_test_pkg;

  localparam int ADDR_W  = 8;
  localparam int TAG_W   = 4;
  localparam int INDEX_W = 4;
  localparam int DATA_W  = 16;

  typedef logic [DATA_W-1:0] data_t;

  // Tag sits above the index, so consecutive word addresses walk the lines
  typedef struct packed {
    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] index;
  } addr_fields_t;

  // The memory reads the flat word, the cache reads tag and index
  typedef union packed {
    logic [ADDR_W-1:0] word;
    addr_fields_t      fields;
  } addr_t;

  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t data;
  } cache_req_t;

  typedef struct packed {
    logic  valid;
    data_t data;
    logic  hit;
  } cache_resp_t;

  typedef struct packed {
    logic  rd;
    logic  wr;
    addr_t addr;
    data_t data;
  } mem_req_t;

  // Test pattern is the zero-extended address XOR this key
  localparam data_t DATA_KEY = 16'hA5C3;

endpackage

`default_nettype wire
